/* rtl/id_consts.svh */
// ------------------------------------------------
// decode/dispatch constants
// alpha opcodes and function codes, alu function
// codes, operand selects and buffer slot sources
// ------------------------------------------------
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define PAL_INST      6'h00  // pal call, inst[25:0] is the function
`define LDA_INST      6'h08
`define INTA_GRP      6'h10  // integer arithmetic and compare
`define INTL_GRP      6'h11  // integer logic
`define INTS_GRP      6'h12  // integer shift
`define INTM_GRP      6'h13  // integer multiply
`define FLTI_GRP      6'h16  // ieee float, not supported
`define JSR_GRP       6'h1a  // jmp, jsr, ret, jsr_co
`define LDQ_INST      6'h29
`define LDQ_L_INST    6'h2b  // load-locked, not supported
`define STQ_INST      6'h2d
`define STQ_C_INST    6'h2f  // store-conditional, not supported
`define BR_INST       6'h30
`define FBEQ_INST     6'h31
`define FBLT_INST     6'h32
`define FBLE_INST     6'h33
`define BSR_INST      6'h34
`define FBNE_INST     6'h35
`define FBGE_INST     6'h36
`define FBGT_INST     6'h37
`define BEQ_INST      6'h39
`define BNE_INST      6'h3d

`define PAL_HALT      26'h555
`define PAL_WHAMI     26'h03c  // cpuid, not supported

`define ADDQ_INST     7'h20  // inta
`define SUBQ_INST     7'h29
`define CMPEQ_INST    7'h2d
`define CMPULT_INST   7'h1d
`define CMPULE_INST   7'h3d
`define CMPLT_INST    7'h4d
`define CMPLE_INST    7'h6d
`define AND_INST      7'h00  // intl
`define BIC_INST      7'h08
`define BIS_INST      7'h20
`define ORNOT_INST    7'h28
`define XOR_INST      7'h40
`define EQV_INST      7'h48
`define SRL_INST      7'h34  // ints
`define SLL_INST      7'h39
`define SRA_INST      7'h3c
`define MULQ_INST     7'h20  // intm

`define ALU_ADDQ      5'h00
`define ALU_SUBQ      5'h01
`define ALU_AND       5'h02
`define ALU_BIC       5'h03
`define ALU_BIS       5'h04
`define ALU_ORNOT     5'h05
`define ALU_XOR       5'h06
`define ALU_EQV       5'h07
`define ALU_SRL       5'h08
`define ALU_SLL       5'h09
`define ALU_SRA       5'h0a
`define ALU_MULQ      5'h0b
`define ALU_CMPEQ     5'h0c
`define ALU_CMPLT     5'h0d
`define ALU_CMPLE     5'h0e
`define ALU_CMPULT    5'h0f
`define ALU_CMPULE    5'h10

`define ALU_OPA_IS_REGA     2'h0
`define ALU_OPA_IS_NPC      2'h1
`define ALU_OPA_IS_NOT3     2'h2  // ~3 mask for jump targets
`define ALU_OPA_IS_MEM_DISP 2'h3

`define ALU_OPB_IS_REGB     2'h0
`define ALU_OPB_IS_ALU_IMM  2'h1  // 8-bit literal, inst[20:13]
`define ALU_OPB_IS_BR_DISP  2'h2

`define ZERO_REG      5'd31  // r31 reads zero, writes dropped

`define SRC_SLOT0     2'd0
`define SRC_SLOT1     2'd1
`define SRC_LANE0     2'd2
`define SRC_LANE1     2'd3

`define NUM_LANES     2

`endif

/* rtl/isa_pkg.sv */
// ------------------------------------------------
// isa_pkg
// instruction word and decoded field types
// ------------------------------------------------
package isa_pkg;

  typedef logic [31:0] inst_t;     // raw instruction word
  typedef logic [4:0]  reg_idx_t;  // architectural register index
  typedef logic [4:0]  alu_func_t; // alu operation code
  typedef logic [1:0]  opa_sel_t;  // operand a mux select
  typedef logic [1:0]  opb_sel_t;  // operand b mux select

endpackage

/* rtl/dispatch_pkg.sv */
// ------------------------------------------------
// dispatch_pkg
// buffer occupancy, counts and slot sources
// ------------------------------------------------
package dispatch_pkg;

  typedef logic [1:0] count_t;     // 0..2 instructions
  typedef logic [1:0] slot_src_t;  // slot load source, see SRC_*

  typedef enum logic [1:0] {
    OCC_EMPTY = 2'd0,
    OCC_ONE   = 2'd1,
    OCC_FULL  = 2'd2
  } occ_state_t;

endpackage

/* rtl/dec_if.sv */
// ------------------------------------------------
// dec_if
// one decoded instruction, decoder to buffer
// ------------------------------------------------
`timescale 1ns/1ps

interface dec_if;
  import isa_pkg::*;

  opa_sel_t  opa_sel;
  opb_sel_t  opb_sel;
  alu_func_t alu_func;
  reg_idx_t  ra_idx;
  reg_idx_t  rb_idx;
  reg_idx_t  dest_idx;       // ZERO_REG when nothing is written
  logic      rd_mem;
  logic      wr_mem;
  logic      cond_branch;
  logic      uncond_branch;  // br, bsr and jumps
  logic      halt;
  logic      illegal;

  modport producer (output opa_sel, opb_sel, alu_func, ra_idx, rb_idx, dest_idx,
                    rd_mem, wr_mem, cond_branch, uncond_branch, halt, illegal);
  modport consumer (input opa_sel, opb_sel, alu_func, ra_idx, rb_idx, dest_idx,
                    rd_mem, wr_mem, cond_branch, uncond_branch, halt, illegal);

endinterface

/* rtl/inst_decoder.sv */
// ------------------------------------------------
// inst_decoder
// combinational alpha-subset decode: operand
// selects, alu function, register indices and
// control flags; unsupported encodings come out
// as an illegal no-op
// ------------------------------------------------
`timescale 1ns/1ps
`include "id_consts.svh"

module inst_decoder (
  input isa_pkg::inst_t inst,
  dec_if.producer       dec
);
  import isa_pkg::*;

  logic [5:0] opcode;
  logic [6:0] func;    // operate-format function field
  reg_idx_t   ra_idx;
  reg_idx_t   rc_idx;
  logic       ok;      // encoding is supported

  assign opcode = inst[31:26];
  assign func   = inst[11:5];
  assign ra_idx = inst[25:21];
  assign rc_idx = inst[4:0];

  assign dec.ra_idx = ra_idx;      // fixed fields, meaningful or not
  assign dec.rb_idx = inst[20:16];

  always_comb
  begin
    dec.opa_sel       = `ALU_OPA_IS_REGA;  // no-op defaults
    dec.opb_sel       = `ALU_OPB_IS_REGB;
    dec.alu_func      = '0;
    dec.dest_idx      = `ZERO_REG;
    dec.rd_mem        = 1'b0;
    dec.wr_mem        = 1'b0;
    dec.cond_branch   = 1'b0;
    dec.uncond_branch = 1'b0;
    dec.halt          = 1'b0;
    ok                = 1'b0;
    case (opcode[5:3])
      3'b000:
      begin
        if ((opcode == `PAL_INST) && (inst[25:0] == `PAL_HALT))
        begin
          dec.halt = 1'b1;  // whami and other pal calls stay illegal
          ok       = 1'b1;
        end
      end
      3'b010:
      begin
        ok = 1'b1;          // cleared below on unknown function
        case (opcode)
          `INTA_GRP:
            case (func)
              `ADDQ_INST:   dec.alu_func = `ALU_ADDQ;
              `SUBQ_INST:   dec.alu_func = `ALU_SUBQ;
              `CMPEQ_INST:  dec.alu_func = `ALU_CMPEQ;
              `CMPULT_INST: dec.alu_func = `ALU_CMPULT;
              `CMPULE_INST: dec.alu_func = `ALU_CMPULE;
              `CMPLT_INST:  dec.alu_func = `ALU_CMPLT;
              `CMPLE_INST:  dec.alu_func = `ALU_CMPLE;
              default:      ok = 1'b0;
            endcase
          `INTL_GRP:
            case (func)
              `AND_INST:    dec.alu_func = `ALU_AND;
              `BIC_INST:    dec.alu_func = `ALU_BIC;
              `BIS_INST:    dec.alu_func = `ALU_BIS;
              `ORNOT_INST:  dec.alu_func = `ALU_ORNOT;
              `XOR_INST:    dec.alu_func = `ALU_XOR;
              `EQV_INST:    dec.alu_func = `ALU_EQV;
              default:      ok = 1'b0;
            endcase
          `INTS_GRP:
            case (func)
              `SRL_INST:    dec.alu_func = `ALU_SRL;
              `SLL_INST:    dec.alu_func = `ALU_SLL;
              `SRA_INST:    dec.alu_func = `ALU_SRA;
              default:      ok = 1'b0;
            endcase
          `INTM_GRP:
            if (func == `MULQ_INST)
              dec.alu_func = `ALU_MULQ;
            else
              ok = 1'b0;
          default:
            ok = 1'b0;      // itfp and float groups
        endcase
        if (ok)
        begin
          dec.opa_sel  = `ALU_OPA_IS_REGA;
          dec.opb_sel  = inst[12] ? `ALU_OPB_IS_ALU_IMM : `ALU_OPB_IS_REGB;
          dec.dest_idx = rc_idx;
        end
      end
      3'b011:
      begin
        if (opcode == `JSR_GRP)  // all four jump flavours behave the same
        begin
          dec.opa_sel       = `ALU_OPA_IS_NOT3;
          dec.opb_sel       = `ALU_OPB_IS_REGB;
          dec.alu_func      = `ALU_AND;  // word-align the target
          dec.dest_idx      = ra_idx;    // return address
          dec.uncond_branch = 1'b1;
          ok                = 1'b1;
        end
      end
      3'b001, 3'b100, 3'b101:
      begin
        case (opcode)
          `LDA_INST:
          begin
            dec.dest_idx = ra_idx;
            ok           = 1'b1;
          end
          `LDQ_INST:
          begin
            dec.rd_mem   = 1'b1;
            dec.dest_idx = ra_idx;
            ok           = 1'b1;
          end
          `STQ_INST:
          begin
            dec.wr_mem = 1'b1;  // no register result
            ok         = 1'b1;
          end
          default: ;            // ldq_l, stq_c and the rest
        endcase
        if (ok)
        begin
          dec.opa_sel  = `ALU_OPA_IS_MEM_DISP;
          dec.opb_sel  = `ALU_OPB_IS_REGB;
          dec.alu_func = `ALU_ADDQ;  // effective address
        end
      end
      default:
      begin
        ok = 1'b1;
        case (opcode)
          `FBEQ_INST, `FBLT_INST, `FBLE_INST, `FBNE_INST, `FBGE_INST, `FBGT_INST:
            ok = 1'b0;          // fp branches
          `BR_INST, `BSR_INST:
          begin
            dec.uncond_branch = 1'b1;
            dec.dest_idx      = ra_idx;  // link register
          end
          default:
            dec.cond_branch = 1'b1;
        endcase
        if (ok)
        begin
          dec.opa_sel  = `ALU_OPA_IS_NPC;
          dec.opb_sel  = `ALU_OPB_IS_BR_DISP;
          dec.alu_func = `ALU_ADDQ;  // target = npc + disp
        end
      end
    endcase
    dec.illegal = ~ok;
  end

endmodule

/* rtl/dispatch_ctrl.sv */
// ------------------------------------------------
// dispatch_ctrl
// buffer occupancy FSM; works out dispatch count,
// fetch need and where each slot loads from
// ------------------------------------------------
`timescale 1ns/1ps
`include "id_consts.svh"

module dispatch_ctrl (
  input  logic                    clock,
  input  logic                    reset,
  input  dispatch_pkg::count_t    rob_cap,
  input  dispatch_pkg::count_t    rs_cap,
  input  logic                    in_valid0,
  input  logic                    in_valid1,
  output dispatch_pkg::count_t    dispatch_num,
  output dispatch_pkg::count_t    fetch_need,
  output dispatch_pkg::slot_src_t slot0_src,
  output dispatch_pkg::slot_src_t slot1_src
);
  import dispatch_pkg::*;

  occ_state_t occ;          // slots holding instructions
  occ_state_t occ_next;
  count_t     occ_cnt;
  count_t     remaining;    // left in buffer after this edge
  count_t     lanes_valid;  // leading valid lanes from fetch
  count_t     accepted;
  count_t     occ_sum;

  assign occ_cnt = count_t'(occ);

  always_comb
  begin
    dispatch_num = occ_cnt;  // never above 2
    if (rob_cap < dispatch_num)
      dispatch_num = rob_cap;
    if (rs_cap < dispatch_num)
      dispatch_num = rs_cap;
  end

  assign remaining   = occ_cnt - dispatch_num;
  assign fetch_need  = count_t'(`NUM_LANES) - remaining;
  assign lanes_valid = in_valid0 ? (in_valid1 ? 2'd2 : 2'd1) : 2'd0;  // lane1 alone ignored
  assign accepted    = (lanes_valid > fetch_need) ? fetch_need : lanes_valid;
  assign occ_sum     = remaining + accepted;

  // leftovers shift down, new lanes go in behind them
  assign slot0_src = (remaining != 2'd0) ?
                     ((dispatch_num == 2'd0) ? `SRC_SLOT0 : `SRC_SLOT1) : `SRC_LANE0;
  assign slot1_src = (remaining == 2'd2) ? `SRC_SLOT1 :
                     ((remaining == 2'd1) ? `SRC_LANE0 : `SRC_LANE1);

  always_comb
  begin
    case (occ_sum)
      2'd0:    occ_next = OCC_EMPTY;
      2'd1:    occ_next = OCC_ONE;
      default: occ_next = OCC_FULL;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      occ <= OCC_EMPTY;
    else
      occ <= occ_next;
  end

endmodule

/* rtl/dispatch_buffer.sv */
// ------------------------------------------------
// dispatch_buffer
// two in-order slots of decoded instructions;
// each slot reloads every cycle from its source
// ------------------------------------------------
`timescale 1ns/1ps
`include "id_consts.svh"

module dispatch_buffer (
  input  logic                    clock,
  input  logic                    reset,
  dec_if.consumer                 lane0,
  dec_if.consumer                 lane1,
  input  dispatch_pkg::slot_src_t slot0_src,
  input  dispatch_pkg::slot_src_t slot1_src,
  output isa_pkg::opa_sel_t       out0_opa_sel,
  output isa_pkg::opb_sel_t       out0_opb_sel,
  output isa_pkg::alu_func_t      out0_alu_func,
  output isa_pkg::reg_idx_t       out0_ra_idx,
  output isa_pkg::reg_idx_t       out0_rb_idx,
  output isa_pkg::reg_idx_t       out0_dest_idx,
  output logic                    out0_rd_mem,
  output logic                    out0_wr_mem,
  output logic                    out0_cond_branch,
  output logic                    out0_uncond_branch,
  output logic                    out0_halt,
  output logic                    out0_illegal,
  output isa_pkg::opa_sel_t       out1_opa_sel,
  output isa_pkg::opb_sel_t       out1_opb_sel,
  output isa_pkg::alu_func_t      out1_alu_func,
  output isa_pkg::reg_idx_t       out1_ra_idx,
  output isa_pkg::reg_idx_t       out1_rb_idx,
  output isa_pkg::reg_idx_t       out1_dest_idx,
  output logic                    out1_rd_mem,
  output logic                    out1_wr_mem,
  output logic                    out1_cond_branch,
  output logic                    out1_uncond_branch,
  output logic                    out1_halt,
  output logic                    out1_illegal
);
  import dispatch_pkg::*;

  localparam int ENTRY_W = 30;  // 2+2+5+5+5+5 plus six flags
  typedef logic [ENTRY_W-1:0] entry_t;
  localparam entry_t NOP_ENTRY = {19'd0, `ZERO_REG, 6'd0};

  entry_t    lane_ent [`NUM_LANES];
  entry_t    slot_q   [`NUM_LANES];
  entry_t    slot_d   [`NUM_LANES];
  slot_src_t src      [`NUM_LANES];

  assign lane_ent[0] = {lane0.opa_sel, lane0.opb_sel, lane0.alu_func, lane0.ra_idx,
                        lane0.rb_idx, lane0.dest_idx, lane0.rd_mem, lane0.wr_mem,
                        lane0.cond_branch, lane0.uncond_branch, lane0.halt, lane0.illegal};
  assign lane_ent[1] = {lane1.opa_sel, lane1.opb_sel, lane1.alu_func, lane1.ra_idx,
                        lane1.rb_idx, lane1.dest_idx, lane1.rd_mem, lane1.wr_mem,
                        lane1.cond_branch, lane1.uncond_branch, lane1.halt, lane1.illegal};
  assign src[0] = slot0_src;
  assign src[1] = slot1_src;

  always_comb
  begin
    for (int k = 0; k < `NUM_LANES; k++)
    begin
      case (src[k])
        `SRC_SLOT0: slot_d[k] = slot_q[0];  // hold or shift down
        `SRC_SLOT1: slot_d[k] = slot_q[1];
        `SRC_LANE0: slot_d[k] = lane_ent[0];
        default:    slot_d[k] = lane_ent[1];
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      slot_q[0] <= NOP_ENTRY;
      slot_q[1] <= NOP_ENTRY;
    end
    else
    begin
      slot_q[0] <= slot_d[0];
      slot_q[1] <= slot_d[1];
    end
  end

  assign {out0_opa_sel, out0_opb_sel, out0_alu_func, out0_ra_idx, out0_rb_idx,
          out0_dest_idx, out0_rd_mem, out0_wr_mem, out0_cond_branch,
          out0_uncond_branch, out0_halt, out0_illegal} = slot_q[0];
  assign {out1_opa_sel, out1_opb_sel, out1_alu_func, out1_ra_idx, out1_rb_idx,
          out1_dest_idx, out1_rd_mem, out1_wr_mem, out1_cond_branch,
          out1_uncond_branch, out1_halt, out1_illegal} = slot_q[1];

endmodule

/* rtl/id_dispatch.sv */
// ------------------------------------------------
// id_dispatch
// two-wide decode and in-order dispatch stage
// with count-based flow control to fetch and to
// the rob/reservation stations
// ------------------------------------------------
`timescale 1ns/1ps

module id_dispatch (
  input  logic                 clock,
  input  logic                 reset,
  input  isa_pkg::inst_t       in_inst0,
  input  isa_pkg::inst_t       in_inst1,
  input  logic                 in_valid0,
  input  logic                 in_valid1,   // only with in_valid0
  input  dispatch_pkg::count_t rob_cap,
  input  dispatch_pkg::count_t rs_cap,
  output dispatch_pkg::count_t dispatch_num,
  output dispatch_pkg::count_t fetch_need,
  output isa_pkg::opa_sel_t    out0_opa_sel,
  output isa_pkg::opb_sel_t    out0_opb_sel,
  output isa_pkg::alu_func_t   out0_alu_func,
  output isa_pkg::reg_idx_t    out0_ra_idx,
  output isa_pkg::reg_idx_t    out0_rb_idx,
  output isa_pkg::reg_idx_t    out0_dest_idx,
  output logic                 out0_rd_mem,
  output logic                 out0_wr_mem,
  output logic                 out0_cond_branch,
  output logic                 out0_uncond_branch,
  output logic                 out0_halt,
  output logic                 out0_illegal,
  output isa_pkg::opa_sel_t    out1_opa_sel,
  output isa_pkg::opb_sel_t    out1_opb_sel,
  output isa_pkg::alu_func_t   out1_alu_func,
  output isa_pkg::reg_idx_t    out1_ra_idx,
  output isa_pkg::reg_idx_t    out1_rb_idx,
  output isa_pkg::reg_idx_t    out1_dest_idx,
  output logic                 out1_rd_mem,
  output logic                 out1_wr_mem,
  output logic                 out1_cond_branch,
  output logic                 out1_uncond_branch,
  output logic                 out1_halt,
  output logic                 out1_illegal
);
  import dispatch_pkg::*;

  dec_if     lane0_dec ();  // decoded lane 0
  dec_if     lane1_dec ();
  slot_src_t slot0_src;
  slot_src_t slot1_src;

  inst_decoder u_dec0 (
    .inst (in_inst0),
    .dec  (lane0_dec)
  );

  inst_decoder u_dec1 (
    .inst (in_inst1),
    .dec  (lane1_dec)
  );

  dispatch_ctrl u_ctrl (.*);  // same names as the top ports

  dispatch_buffer u_buf (
    .lane0 (lane0_dec),
    .lane1 (lane1_dec),
    .*
  );

endmodule

/* test/id_dispatch_chk.sv */
// --------------------------------------------------
// id_dispatch_chk
// concurrent checks on the dispatch controller
// bound into every dispatch_ctrl instance
// --------------------------------------------------
`timescale 1ns/1ps

module id_dispatch_chk (
  input logic                 clock,
  input logic                 reset,
  input dispatch_pkg::count_t rob_cap,
  input dispatch_pkg::count_t rs_cap,
  input logic                 in_valid0,
  input logic                 in_valid1,
  input dispatch_pkg::count_t dispatch_num,
  input dispatch_pkg::count_t fetch_need,
  input dispatch_pkg::count_t occ_cnt
);

  int unsigned fail_count = 0;  // failed assertions so far

  a_dnum_bound: assert property (@(posedge clock) disable iff (reset)
    (dispatch_num <= rob_cap) && (dispatch_num <= rs_cap) && (dispatch_num <= occ_cnt))
  else
  begin
    fail_count = fail_count + 1;
    $error("dispatch_num is above a capacity or the buffer occupancy");
  end

  // free slots after dispatch always sum back to two
  a_need_sum: assert property (@(posedge clock) disable iff (reset)
    (int'(fetch_need) + int'(occ_cnt) - int'(dispatch_num)) == 2)
  else
  begin
    fail_count = fail_count + 1;
    $error("fetch_need does not match the free slots after dispatch");
  end

  // fetch offers leading lanes only, never more than fetch_need
  a_fetch_bound: assert property (@(posedge clock) disable iff (reset)
    (!in_valid1 || in_valid0) && ((int'(in_valid0) + int'(in_valid1)) <= int'(fetch_need)))
  else
  begin
    fail_count = fail_count + 1;
    $error("fetch presented more lanes than fetch_need allows");
  end

endmodule

bind dispatch_ctrl id_dispatch_chk u_chk (
  .clock        (clock),
  .reset        (reset),
  .rob_cap      (rob_cap),
  .rs_cap       (rs_cap),
  .in_valid0    (in_valid0),
  .in_valid1    (in_valid1),
  .dispatch_num (dispatch_num),
  .fetch_need   (fetch_need),
  .occ_cnt      (occ_cnt)
);

/* test/id_dispatch_tb.sv */
// --------------------------------------------------
// id_dispatch testbench
// feeds a table of instructions through both fetch
// lanes under lfsr-chosen capacities and compares
// dispatch counts and buffered fields with a queue
// model of the dispatch buffer
// --------------------------------------------------
`timescale 1ns/1ps
`include "id_consts.svh"

module id_dispatch_tb;
  import isa_pkg::*;
  import dispatch_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int N_ROWS          = 24;
  localparam int WATCHDOG_CYCLES = N_ROWS * 8;

  // flags are {rd_mem wr_mem cond uncond halt illegal}
  localparam logic [5:0] F_NONE = 6'b000000;
  localparam logic [5:0] F_RD   = 6'b100000;
  localparam logic [5:0] F_WR   = 6'b010000;
  localparam logic [5:0] F_COND = 6'b001000;
  localparam logic [5:0] F_UNC  = 6'b000100;
  localparam logic [5:0] F_HALT = 6'b000010;
  localparam logic [5:0] F_ILL  = 6'b000001;

  logic      clock = 1'b0;
  logic      reset;
  inst_t     in_inst0;
  inst_t     in_inst1;
  logic      in_valid0;
  logic      in_valid1;
  count_t    rob_cap;
  count_t    rs_cap;
  count_t    dispatch_num;
  count_t    fetch_need;
  opa_sel_t  out0_opa_sel, out1_opa_sel;
  opb_sel_t  out0_opb_sel, out1_opb_sel;
  alu_func_t out0_alu_func, out1_alu_func;
  reg_idx_t  out0_ra_idx, out1_ra_idx;
  reg_idx_t  out0_rb_idx, out1_rb_idx;
  reg_idx_t  out0_dest_idx, out1_dest_idx;
  logic      out0_rd_mem, out1_rd_mem;
  logic      out0_wr_mem, out1_wr_mem;
  logic      out0_cond_branch, out1_cond_branch;
  logic      out0_uncond_branch, out1_uncond_branch;
  logic      out0_halt, out1_halt;
  logic      out0_illegal, out1_illegal;

  logic [29:0] act0;               // slot 0 as one word
  logic [29:0] act1;

  string       row_name [N_ROWS];
  inst_t       row_inst [N_ROWS];
  logic [29:0] row_exp  [N_ROWS];  // {opa opb func ra rb dest flags}
  int          n_fill;

  logic [31:0] lfsr = 32'ha0c5;
  int          q [$];              // row indices in the buffer, slot 0 first
  int          next_row;           // next table row to fetch
  int          cur_dnum;           // expected for the coming edge
  int          cur_acc;
  int          exp_need;

  id_dispatch u_id_dispatch (.*);

  assign act0 = {out0_opa_sel, out0_opb_sel, out0_alu_func, out0_ra_idx, out0_rb_idx,
                 out0_dest_idx, out0_rd_mem, out0_wr_mem, out0_cond_branch,
                 out0_uncond_branch, out0_halt, out0_illegal};
  assign act1 = {out1_opa_sel, out1_opb_sel, out1_alu_func, out1_ra_idx, out1_rb_idx,
                 out1_dest_idx, out1_rd_mem, out1_wr_mem, out1_cond_branch,
                 out1_uncond_branch, out1_halt, out1_illegal};

  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);  // one step per bit
    end
    return v;
  endfunction

  function automatic int limit_two(input logic [31:0] v);
    return (v > 32'd2) ? 2 : int'(v);
  endfunction

  function automatic inst_t op_word(input logic [5:0] opc, input reg_idx_t ra,
                                    input reg_idx_t rb, input logic [6:0] fn,
                                    input reg_idx_t rc);
    return {opc, ra, rb, 3'b000, 1'b0, fn, rc};
  endfunction

  function automatic inst_t lit_word(input logic [5:0] opc, input reg_idx_t ra,
                                     input logic [7:0] lit, input logic [6:0] fn,
                                     input reg_idx_t rc);
    return {opc, ra, lit, 1'b1, fn, rc};  // rb field is lit[7:3]
  endfunction

  function automatic inst_t mem_word(input logic [5:0] opc, input reg_idx_t ra,
                                     input reg_idx_t rb, input logic [15:0] disp);
    return {opc, ra, rb, disp};
  endfunction

  function automatic inst_t br_word(input logic [5:0] opc, input reg_idx_t ra,
                                    input logic [20:0] disp);
    return {opc, ra, disp};  // rb field is disp[20:16]
  endfunction

  task automatic check(input string name, input logic [31:0] exp_v,
                       input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("** Error %s: expected %h, actual %h", name, exp_v, act_v);
      $display("Simulation failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic add_row(input string name, input inst_t inst, input opa_sel_t opa,
                         input opb_sel_t opb, input alu_func_t fn, input reg_idx_t ra,
                         input reg_idx_t rb, input reg_idx_t dest, input logic [5:0] flags);
    row_name[n_fill] = name;
    row_inst[n_fill] = inst;
    row_exp[n_fill]  = {opa, opb, fn, ra, rb, dest, flags};
    n_fill++;
  endtask

  task automatic fill_table();
    add_row("addq_reg", op_word(`INTA_GRP, 5'd1, 5'd2, `ADDQ_INST, 5'd3),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, `ALU_ADDQ, 5'd1, 5'd2, 5'd3, F_NONE);
    add_row("subq_lit", lit_word(`INTA_GRP, 5'd4, 8'h5a, `SUBQ_INST, 5'd5),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_ALU_IMM, `ALU_SUBQ, 5'd4, 5'd11, 5'd5, F_NONE);
    add_row("cmplt_reg", op_word(`INTA_GRP, 5'd6, 5'd7, `CMPLT_INST, 5'd8),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, `ALU_CMPLT, 5'd6, 5'd7, 5'd8, F_NONE);
    add_row("cmpule_lit", lit_word(`INTA_GRP, 5'd9, 8'h10, `CMPULE_INST, 5'd10),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_ALU_IMM, `ALU_CMPULE, 5'd9, 5'd2, 5'd10, F_NONE);
    add_row("bis_reg", op_word(`INTL_GRP, 5'd11, 5'd12, `BIS_INST, 5'd13),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, `ALU_BIS, 5'd11, 5'd12, 5'd13, F_NONE);
    add_row("xor_lit", lit_word(`INTL_GRP, 5'd14, 8'hff, `XOR_INST, 5'd15),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_ALU_IMM, `ALU_XOR, 5'd14, 5'd31, 5'd15, F_NONE);
    add_row("sra_reg", op_word(`INTS_GRP, 5'd16, 5'd17, `SRA_INST, 5'd18),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, `ALU_SRA, 5'd16, 5'd17, 5'd18, F_NONE);
    add_row("sll_lit", lit_word(`INTS_GRP, 5'd19, 8'h3f, `SLL_INST, 5'd20),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_ALU_IMM, `ALU_SLL, 5'd19, 5'd7, 5'd20, F_NONE);
    add_row("mulq_reg", op_word(`INTM_GRP, 5'd21, 5'd22, `MULQ_INST, 5'd23),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, `ALU_MULQ, 5'd21, 5'd22, 5'd23, F_NONE);
    add_row("lda", mem_word(`LDA_INST, 5'd24, 5'd25, 16'h1234),
            `ALU_OPA_IS_MEM_DISP, `ALU_OPB_IS_REGB, `ALU_ADDQ, 5'd24, 5'd25, 5'd24, F_NONE);
    add_row("ldq", mem_word(`LDQ_INST, 5'd1, 5'd2, 16'hfff8),
            `ALU_OPA_IS_MEM_DISP, `ALU_OPB_IS_REGB, `ALU_ADDQ, 5'd1, 5'd2, 5'd1, F_RD);
    add_row("stq", mem_word(`STQ_INST, 5'd3, 5'd4, 16'h0010),
            `ALU_OPA_IS_MEM_DISP, `ALU_OPB_IS_REGB, `ALU_ADDQ, 5'd3, 5'd4, `ZERO_REG, F_WR);
    add_row("br", br_word(`BR_INST, 5'd26, 21'h1abcd),
            `ALU_OPA_IS_NPC, `ALU_OPB_IS_BR_DISP, `ALU_ADDQ, 5'd26, 5'd1, 5'd26, F_UNC);
    add_row("bsr", br_word(`BSR_INST, 5'd26, 21'h150000),
            `ALU_OPA_IS_NPC, `ALU_OPB_IS_BR_DISP, `ALU_ADDQ, 5'd26, 5'd21, 5'd26, F_UNC);
    add_row("beq", br_word(`BEQ_INST, 5'd2, 21'h1ffffc),
            `ALU_OPA_IS_NPC, `ALU_OPB_IS_BR_DISP, `ALU_ADDQ, 5'd2, 5'd31, `ZERO_REG, F_COND);
    add_row("bne", br_word(`BNE_INST, 5'd5, 21'h000004),
            `ALU_OPA_IS_NPC, `ALU_OPB_IS_BR_DISP, `ALU_ADDQ, 5'd5, 5'd0, `ZERO_REG, F_COND);
    add_row("jsr", mem_word(`JSR_GRP, 5'd26, 5'd27, 16'h4000),
            `ALU_OPA_IS_NOT3, `ALU_OPB_IS_REGB, `ALU_AND, 5'd26, 5'd27, 5'd26, F_UNC);
    add_row("halt", {`PAL_INST, `PAL_HALT},
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd0, 5'd0, `ZERO_REG, F_HALT);
    add_row("whami", {`PAL_INST, `PAL_WHAMI},
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd0, 5'd0, `ZERO_REG, F_ILL);
    add_row("ldq_l", mem_word(`LDQ_L_INST, 5'd3, 5'd4, 16'h0008),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd3, 5'd4, `ZERO_REG, F_ILL);
    add_row("stq_c", mem_word(`STQ_C_INST, 5'd5, 5'd6, 16'h0000),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd5, 5'd6, `ZERO_REG, F_ILL);
    add_row("float_op", op_word(`FLTI_GRP, 5'd7, 5'd8, 7'h20, 5'd9),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd7, 5'd8, `ZERO_REG, F_ILL);
    add_row("fbeq", br_word(`FBEQ_INST, 5'd1, 21'h000100),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd1, 5'd0, `ZERO_REG, F_ILL);
    add_row("inta_bad_func", op_word(`INTA_GRP, 5'd2, 5'd3, 7'h7f, 5'd4),
            `ALU_OPA_IS_REGA, `ALU_OPB_IS_REGB, 5'h00, 5'd2, 5'd3, `ZERO_REG, F_ILL);
  endtask

  // what the dut did at the edge just taken
  task automatic commit_edge();
    for (int k = 0; k < cur_dnum; k++)
      void'(q.pop_front());
    for (int k = 0; k < cur_acc; k++)
    begin
      q.push_back(next_row);  // lanes go in behind leftovers
      next_row++;
    end
  endtask

  task automatic drive_cycle();
    int rob_i;
    int rs_i;
    int lanes;
    rob_i    = limit_two(rand_bits(2));
    rs_i     = limit_two(rand_bits(2));
    cur_dnum = q.size();
    if (rob_i < cur_dnum)
      cur_dnum = rob_i;
    if (rs_i < cur_dnum)
      cur_dnum = rs_i;
    exp_need = 2 - (q.size() - cur_dnum);
    lanes    = limit_two(rand_bits(2));
    if (lanes > exp_need)
      lanes = exp_need;
    if (lanes > N_ROWS - next_row)
      lanes = N_ROWS - next_row;  // table running out
    cur_acc   = lanes;
    rob_cap   <= count_t'(rob_i);
    rs_cap    <= count_t'(rs_i);
    in_valid0 <= (lanes > 0);
    in_valid1 <= (lanes > 1);
    if (lanes > 0)
      in_inst0 <= row_inst[next_row];
    else
      in_inst0 <= rand_bits(32);  // junk on an idle lane
    if (lanes > 1)
      in_inst1 <= row_inst[next_row + 1];
    else
      in_inst1 <= rand_bits(32);
  endtask

  task automatic check_outputs();
    check("dispatch_num", 32'(cur_dnum), 32'(dispatch_num));
    check("fetch_need", 32'(exp_need), 32'(fetch_need));
    check("bound assertions", 32'd0, u_id_dispatch.u_ctrl.u_chk.fail_count);
    if (q.size() > 0)
      check($sformatf("%s in slot 0", row_name[q[0]]), 32'(row_exp[q[0]]), 32'(act0));
    if (q.size() > 1)
      check($sformatf("%s in slot 1", row_name[q[1]]), 32'(row_exp[q[1]]), 32'(act1));
  endtask

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: table not drained after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    reset     = 1'b1;
    in_inst0  = '0;
    in_inst1  = '0;
    in_valid0 = 1'b0;
    in_valid1 = 1'b0;
    rob_cap   = '0;
    rs_cap    = '0;
    n_fill    = 0;
    next_row  = 0;
    cur_dnum  = 0;
    cur_acc   = 0;
    exp_need  = 2;
    fill_table();
    check("table rows", 32'(N_ROWS), 32'(n_fill));
    repeat (3) @(posedge clock);
    reset   <= 1'b0;
    rob_cap <= 2'd2;    // open capacity, buffer still empty
    rs_cap  <= 2'd2;
    @(negedge clock);
    check("reset dispatch_num", 32'd0, 32'(dispatch_num));
    check("reset fetch_need", 32'd2, 32'(fetch_need));
    check("reset slot 0 dest and flags", 32'({`ZERO_REG, F_NONE}), 32'(act0[10:0]));
    check("reset slot 1 dest and flags", 32'({`ZERO_REG, F_NONE}), 32'(act1[10:0]));
    while ((next_row < N_ROWS) || (q.size() != 0))
    begin
      @(posedge clock);
      commit_edge();
      drive_cycle();
      @(negedge clock);  // outputs settled
      check_outputs();
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

/* tb.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/dispatch_pkg.sv
rtl/dec_if.sv
rtl/inst_decoder.sv
rtl/dispatch_ctrl.sv
rtl/dispatch_buffer.sv
rtl/id_dispatch.sv
test/id_dispatch_chk.sv
test/id_dispatch_tb.sv

/* run.sh */
#!/bin/sh
# build and run the id_dispatch testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module id_dispatch_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vid_dispatch_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
